// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Bus timing widths
`define CPU_TSTATE_W 3
`define CPU_MCYCLE_W 3

// Multiplier operand and product widths
`define CPU_MUL_W  16
`define CPU_PROD_W 32

// Counter values after reset and at the start of a machine cycle
`define CPU_MC_FIRST 3'd1
`define CPU_TS_RESET 3'd0
`define CPU_TS_FIRST 3'd1

// Enabled clocks from operand load to a valid product
`define CPU_MUL_WORD_STEPS 4
`define CPU_MUL_BYTE_STEPS 2

// Extra T1 clocks in M1 of an acknowledge cycle
`define CPU_ACK_WAITS 2

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_TSTATE_W-1:0] tState_t;
    typedef logic [`CPU_MCYCLE_W-1:0] mCycle_t;
    typedef logic [`CPU_MUL_W-1:0]    mulWord_t;
    typedef logic [`CPU_PROD_W-1:0]   mulProduct_t;

    // Per-instruction description coming from the instruction decoder
    typedef struct packed {
        mCycle_t mCycles;
        tState_t tStates;
        logic    halt;
        logic    setEi;
        logic    setDi;
        logic    retn;
        logic    ioReq;
    } cycleCtrl_t;

    // Registered versions of the asynchronous control inputs
    typedef struct packed {
        logic busReq;
        logic intReq;
        logic nmiPend;
    } syncIn_t;

    // Kind of the instruction that starts at the next M1
    typedef enum logic [1:0] {
        kindFetch,
        kindNmi,
        kindInt
    } cycleKind_t;

endpackage

`default_nettype wire

// ==== logic/inputSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputSync (
    input  wire              CLK_n,
    input  wire              RESET_n,
    input  wire              CEN,
    input  wire              BUSRQ_n,
    input  wire              INT_n,
    input  wire              NMI_n,
    input  wire              nmiTaken,
    output cpu_pkg::syncIn_t syncIn
);

    // Last sampled NMI_n level
    logic nmiPrev;

    always_ff @(posedge CLK_n) begin
        if (!RESET_n) begin
            syncIn.busReq  <= 1'b0;
            syncIn.intReq  <= 1'b0;
            syncIn.nmiPend <= 1'b0;
            nmiPrev        <= 1'b0;
        end else if (CEN) begin
            syncIn.busReq <= !BUSRQ_n;
            syncIn.intReq <= !INT_n;

            // Acceptance wins over a new edge in the same clock
            if (nmiTaken) begin
                syncIn.nmiPend <= 1'b0;
            end else if (nmiPrev && !NMI_n) begin
                syncIn.nmiPend <= 1'b1;
            end

            nmiPrev <= NMI_n;
        end
    end

    // An NMI taken by intControl must not leave a fresh pending flag behind
    nmiClearOnTake: assert property (
        @(posedge CLK_n) disable iff (!RESET_n)
        nmiTaken |=> !syncIn.nmiPend
    );

endmodule

`default_nettype wire

// ==== logic/intControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module intControl (
    input  wire                  CLK_n,
    input  wire                  RESET_n,
    input  wire                  clkEn,
    input  wire                  instrEnd,
    input  wire cpu_pkg::syncIn_t    syncIn,
    input  wire cpu_pkg::cycleCtrl_t cycleCtrl,
    input  wire cpu_pkg::tState_t    tState,
    output cpu_pkg::cycleKind_t  kind,
    output logic                 nmiTaken,
    output logic                 intEnable,
    output logic                 halted
);

    // Interrupt enable flip-flops where iff2 keeps the state across an NMI
    logic iff1;
    logic iff2;

    // NMI acceptance clears the pending flag in inputSync on the same edge
    assign nmiTaken  = clkEn && instrEnd && syncIn.nmiPend;
    assign intEnable = iff1;

    always_ff @(posedge CLK_n) begin
        if (!RESET_n) begin
            iff1   <= 1'b0;
            iff2   <= 1'b0;
            halted <= 1'b0;
            kind   <= cpu_pkg::kindFetch;
        end else if (clkEn) begin
            if (tState == cpu_pkg::tState_t'(2)) begin
                if (cycleCtrl.setEi) begin
                    iff1 <= 1'b1;
                    iff2 <= 1'b1;
                end
                if (cycleCtrl.retn) begin
                    iff1 <= iff2;
                end
            end

            if (tState == cpu_pkg::tState_t'(3) && cycleCtrl.setDi) begin
                iff1 <= 1'b0;
                iff2 <= 1'b0;
            end

            // Any acknowledge cycle leaves the halt state
            if (kind != cpu_pkg::kindFetch) begin
                halted <= 1'b0;
            end

            if (instrEnd) begin
                if (cycleCtrl.halt) begin
                    halted <= 1'b1;
                end

                // NMI has priority and INT is held off for one instruction after EI
                if (syncIn.nmiPend) begin
                    kind <= cpu_pkg::kindNmi;
                    iff1 <= 1'b0;
                end else if (iff1 && syncIn.intReq && !cycleCtrl.setEi) begin
                    kind <= cpu_pkg::kindInt;
                    iff1 <= 1'b0;
                    iff2 <= 1'b0;
                end else begin
                    kind <= cpu_pkg::kindFetch;
                end
            end
        end
    end

    // A maskable acknowledge only starts when interrupts were enabled
    noIntWhenDisabled: assert property (
        @(posedge CLK_n) disable iff (!RESET_n)
        $rose(kind == cpu_pkg::kindInt) |-> $past(iff1)
    );

endmodule

`default_nettype wire

// ==== logic/cycleSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cycleSequencer (
    input  wire                      CLK_n,
    input  wire                      RESET_n,
    input  wire                      CEN,
    input  wire                      WAIT_n,
    input  wire cpu_pkg::syncIn_t    syncIn,
    input  wire cpu_pkg::cycleCtrl_t cycleCtrl,
    input  wire cpu_pkg::cycleKind_t kind,
    output cpu_pkg::mCycle_t         mCycle,
    output cpu_pkg::tState_t         tState,
    output logic                     instrEnd,
    output logic                     busAck,
    output logic                     M1_n,
    output logic                     RFSH_n
);

    logic tLast;
    logic lastMc;
    logic waitHold;
    logic waitReq;
    logic ackHold;
    logic cycleEnd;
    logic newInstr;

    // Delay line for the automatic wait states at T1
    logic [`CPU_ACK_WAITS-1:0] ackStage;

    always_comb begin
        tLast    = tState == cycleCtrl.tStates;
        lastMc   = mCycle == cycleCtrl.mCycles;
        waitHold = tState == cpu_pkg::tState_t'(2) && !WAIT_n;
        waitReq  = cycleCtrl.ioReq
                   || (mCycle == `CPU_MC_FIRST && kind != cpu_pkg::kindFetch);
        ackHold  = tState == `CPU_TS_FIRST && waitReq && !ackStage[`CPU_ACK_WAITS-1];
        // A pending bus request turns the cycle end into a grant
        cycleEnd = !busAck && tLast && !waitHold && !ackHold && !syncIn.busReq;
        newInstr = cycleEnd && lastMc;
    end

    assign instrEnd = CEN && newInstr;

    always_ff @(posedge CLK_n) begin
        if (!RESET_n) begin
            mCycle   <= `CPU_MC_FIRST;
            tState   <= `CPU_TS_RESET;
            busAck   <= 1'b0;
            ackStage <= '0;
            M1_n     <= 1'b1;
            RFSH_n   <= 1'b1;
        end else if (CEN) begin
            if (busAck) begin
                // Bus goes back first, T1 starts on the following clock
                if (!syncIn.busReq) begin
                    busAck <= 1'b0;
                end
            end else if (cycleEnd) begin
                tState <= `CPU_TS_FIRST;
                mCycle <= lastMc ? `CPU_MC_FIRST : mCycle + 3'd1;
            end else if (tLast && !waitHold && !ackHold) begin
                busAck <= 1'b1;
            end else if (!waitHold && !ackHold) begin
                tState <= tState + 3'd1;
            end

            if (!busAck) begin
                if (cycleEnd) begin
                    ackStage <= '0;
                end else begin
                    ackStage <= {ackStage[`CPU_ACK_WAITS-2:0], waitReq};
                end
            end

            // M1_n low from the start of M1 until T2 is done
            if (newInstr || tState == `CPU_TS_RESET) begin
                M1_n <= 1'b0;
            end else if (mCycle == `CPU_MC_FIRST && tState == cpu_pkg::tState_t'(2) && WAIT_n) begin
                M1_n <= 1'b1;
            end

            // Refresh strobe for the two clocks after M1's T2
            RFSH_n <= !(mCycle == `CPU_MC_FIRST && !newInstr
                        && ((tState == cpu_pkg::tState_t'(2) && WAIT_n)
                            || tState == cpu_pkg::tState_t'(3)));
        end
    end

    tStateInRange: assert property (
        @(posedge CLK_n) disable iff (!RESET_n)
        (tState != `CPU_TS_RESET) |=> (tState != `CPU_TS_RESET
                                       && tState <= cycleCtrl.tStates)
    );

    m1RfshExclusive: assert property (
        @(posedge CLK_n) disable iff (!RESET_n)
        !(!M1_n && !RFSH_n)
    );

endmodule

`default_nettype wire

// ==== logic/mulUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module mulUnit (
    input  wire                   CLK_n,
    input  wire                   clkEn,
    input  wire                   mulLoad,
    input  wire                   byteMode,
    input  wire cpu_pkg::mulWord_t mulA,
    input  wire cpu_pkg::mulWord_t mulB,
    output cpu_pkg::mulProduct_t  mulProduct
);

    // Multiplicand, fixed for the whole product
    cpu_pkg::mulWord_t mcand;

    // Partial product of one nibble and the running upper half
    logic [`CPU_MUL_W+3:0] partial;
    logic [`CPU_MUL_W+3:0] upperSum;

    always_comb begin
        partial  = {4'b0, mcand} * {{`CPU_MUL_W{1'b0}}, mulProduct[3:0]};
        upperSum = partial + {4'b0, mulProduct[`CPU_PROD_W-1:`CPU_MUL_W]};
    end

    always_ff @(posedge CLK_n) begin
        if (clkEn) begin
            if (mulLoad) begin
                if (byteMode) begin
                    // Multiplicand moved up a byte so the result lands in the top half
                    mulProduct <= {24'b0, mulA[7:0]};
                    mcand      <= {mulB[7:0], 8'b0};
                end else begin
                    mulProduct <= {{`CPU_MUL_W{1'b0}}, mulA};
                    mcand      <= mulB;
                end
            end else begin
                // Low nibble consumed, the rest moves down by four
                mulProduct <= {upperSum, mulProduct[`CPU_MUL_W-1:4]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpuTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTiming (
    input  wire                      CLK_n,
    input  wire                      RESET_n,
    input  wire                      CEN,
    input  wire                      WAIT_n,
    input  wire                      INT_n,
    input  wire                      NMI_n,
    input  wire                      BUSRQ_n,
    input  wire                      mulLoad,
    input  wire                      byteMode,
    input  wire cpu_pkg::cycleCtrl_t cycleCtrl,
    input  wire cpu_pkg::mulWord_t   mulA,
    input  wire cpu_pkg::mulWord_t   mulB,
    output logic                     M1_n,
    output logic                     RFSH_n,
    output logic                     BUSAK_n,
    output logic                     HALT_n,
    output logic                     IntCycle_n,
    output logic                     NmiCycle_n,
    output logic                     IntE,
    output cpu_pkg::mCycle_t         MC,
    output cpu_pkg::tState_t         TS,
    output cpu_pkg::mulProduct_t     mulProduct
);

    cpu_pkg::syncIn_t    syncIn;
    cpu_pkg::cycleKind_t kind;
    logic                instrEnd;
    logic                busAck;
    logic                nmiTaken;
    logic                intEnable;
    logic                halted;
    logic                clkEn;

    // Internal work stops while the bus is granted away
    assign clkEn = CEN && !busAck;

    assign BUSAK_n    = !busAck;
    assign HALT_n     = !halted;
    assign IntCycle_n = kind != cpu_pkg::kindInt;
    assign NmiCycle_n = kind != cpu_pkg::kindNmi;
    assign IntE       = intEnable;

    inputSync u_inputSync (
        .CLK_n    (CLK_n),
        .RESET_n  (RESET_n),
        .CEN      (CEN),
        .BUSRQ_n  (BUSRQ_n),
        .INT_n    (INT_n),
        .NMI_n    (NMI_n),
        .nmiTaken (nmiTaken),
        .syncIn   (syncIn)
    );

    intControl u_intControl (
        .CLK_n     (CLK_n),
        .RESET_n   (RESET_n),
        .clkEn     (clkEn),
        .instrEnd  (instrEnd),
        .syncIn    (syncIn),
        .cycleCtrl (cycleCtrl),
        .tState    (TS),
        .kind      (kind),
        .nmiTaken  (nmiTaken),
        .intEnable (intEnable),
        .halted    (halted)
    );

    cycleSequencer u_cycleSequencer (
        .CLK_n     (CLK_n),
        .RESET_n   (RESET_n),
        .CEN       (CEN),
        .WAIT_n    (WAIT_n),
        .syncIn    (syncIn),
        .cycleCtrl (cycleCtrl),
        .kind      (kind),
        .mCycle    (MC),
        .tState    (TS),
        .instrEnd  (instrEnd),
        .busAck    (busAck),
        .M1_n      (M1_n),
        .RFSH_n    (RFSH_n)
    );

    mulUnit u_mulUnit (
        .CLK_n      (CLK_n),
        .clkEn      (clkEn),
        .mulLoad    (mulLoad),
        .byteMode   (byteMode),
        .mulA       (mulA),
        .mulB       (mulB),
        .mulProduct (mulProduct)
    );

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PERIOD      = 8,
    parameter int RESET_COUNT = 3
) (
    output logic CLK_n,
    output logic RESET_n
);

    initial begin
        CLK_n   = 1'b0;
        RESET_n = 1'b0;
    end

    always #(PERIOD / 2) CLK_n = !CLK_n;

    // Reset is released on a rising edge after the hold time
    initial begin
        repeat (RESET_COUNT) @(posedge CLK_n);
        RESET_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/cpuTiming_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpuTiming_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int TEST_COUNT      = 6;
    localparam int CLOCKS_PER_TEST = 200;

    wire  CLK_n;
    wire  RESET_n;
    logic CEN;
    logic WAIT_n;
    logic INT_n;
    logic NMI_n;
    logic BUSRQ_n;
    logic mulLoad;
    logic byteMode;
    cpu_pkg::cycleCtrl_t cycleCtrl;
    cpu_pkg::mulWord_t   mulA;
    cpu_pkg::mulWord_t   mulB;

    logic M1_n;
    logic RFSH_n;
    logic BUSAK_n;
    logic HALT_n;
    logic IntCycle_n;
    logic NmiCycle_n;
    logic IntE;
    cpu_pkg::mCycle_t     MC;
    cpu_pkg::tState_t     TS;
    cpu_pkg::mulProduct_t mulProduct;

    // Interrupt line levels applied at the start of each instruction
    logic        intLine;
    logic        nmiLine;
    logic [31:0] rngState;
    int          errorCount;

    cpu_pkg::cycleCtrl_t nopCtrl;

    clockGen #(.PERIOD(CLK_PERIOD), .RESET_COUNT(3)) u_clockGen (
        .CLK_n   (CLK_n),
        .RESET_n (RESET_n)
    );

    cpuTiming u_cpuTiming (
        .CLK_n      (CLK_n),
        .RESET_n    (RESET_n),
        .CEN        (CEN),
        .WAIT_n     (WAIT_n),
        .INT_n      (INT_n),
        .NMI_n      (NMI_n),
        .BUSRQ_n    (BUSRQ_n),
        .mulLoad    (mulLoad),
        .byteMode   (byteMode),
        .cycleCtrl  (cycleCtrl),
        .mulA       (mulA),
        .mulB       (mulB),
        .M1_n       (M1_n),
        .RFSH_n     (RFSH_n),
        .BUSAK_n    (BUSAK_n),
        .HALT_n     (HALT_n),
        .IntCycle_n (IntCycle_n),
        .NmiCycle_n (NmiCycle_n),
        .IntE       (IntE),
        .MC         (MC),
        .TS         (TS),
        .mulProduct (mulProduct)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift32(rngState);
        value    = rngState;
    endtask

    function automatic cpu_pkg::cycleCtrl_t makeCtrl(input int mc, input int ts,
                                                     input logic halt, input logic ei,
                                                     input logic di, input logic rn);
        cpu_pkg::cycleCtrl_t c;
        c.mCycles = cpu_pkg::mCycle_t'(mc);
        c.tStates = cpu_pkg::tState_t'(ts);
        c.halt    = halt;
        c.setEi   = ei;
        c.setDi   = di;
        c.retn    = rn;
        c.ioReq   = 1'b0;
        return c;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        errorCount = errorCount + 1;
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic compareTState(input cpu_pkg::tState_t got, input cpu_pkg::tState_t expected,
                                 input string what);
        if (got !== expected) begin
            reportMismatch(what, 32'(got), 32'(expected));
        end
    endtask

    task automatic compareMCycle(input cpu_pkg::mCycle_t got, input cpu_pkg::mCycle_t expected,
                                 input string what);
        if (got !== expected) begin
            reportMismatch(what, 32'(got), 32'(expected));
        end
    endtask

    task automatic compareProduct(input cpu_pkg::mulProduct_t got,
                                  input cpu_pkg::mulProduct_t expected, input string what);
        if (got !== expected) begin
            reportMismatch(what, got, expected);
        end
    endtask

    task automatic compareLevel(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            reportMismatch(what, 32'(got), 32'(expected));
        end
    endtask

    // Wait at falling edges until the current instruction shows its last T-state
    task automatic finishInstr(input cpu_pkg::cycleCtrl_t c);
        do begin
            @(negedge CLK_n);
        end while (!(MC == c.mCycles && TS == c.tStates));
    endtask

    // Present one instruction at its first edge and follow every clock of it
    task automatic runInstruction(input cpu_pkg::cycleCtrl_t c, input int waitClocks,
                                  input int ackClocks);
        cpu_pkg::mCycle_t expMc;
        cpu_pkg::tState_t expTs;
        logic isEnd;
        logic done;
        logic nextWait;
        int   waitLeft;
        int   ackLeft;
        int   rfshLeft;
        expMc    = 3'd1;
        expTs    = 3'd1;
        done     = 1'b0;
        waitLeft = waitClocks;
        ackLeft  = ackClocks;
        rfshLeft = 0;
        @(posedge CLK_n);
        cycleCtrl <= c;
        WAIT_n    <= 1'b1;
        INT_n     <= intLine;
        NMI_n     <= nmiLine;
        while (!done) begin
            @(negedge CLK_n);
            compareMCycle(MC, expMc, "MC");
            compareTState(TS, expTs, "TS");
            compareLevel(M1_n, !(expMc == 3'd1 && expTs <= 3'd2), "M1_n");
            compareLevel(RFSH_n, rfshLeft == 0, "RFSH_n");
            if (rfshLeft > 0) begin
                rfshLeft = rfshLeft - 1;
            end
            // Refresh covers the two clocks after M1's T2 completes
            if (expMc == 3'd1 && expTs == 3'd2 && WAIT_n) begin
                rfshLeft = 2;
            end
            isEnd = expMc == c.mCycles && expTs == c.tStates;
            if (isEnd) begin
                done = 1'b1;
            end else if (expMc == 3'd1 && expTs == 3'd1 && ackLeft > 0) begin
                ackLeft = ackLeft - 1;
            end else if (expMc == 3'd1 && expTs == 3'd2 && !WAIT_n) begin
                expTs = expTs;
            end else if (expTs == c.tStates) begin
                expTs = 3'd1;
                expMc = expMc + 3'd1;
            end else begin
                expTs = expTs + 3'd1;
            end
            if (!done) begin
                nextWait = 1'b1;
                if (expMc == 3'd1 && expTs == 3'd2 && waitLeft > 0) begin
                    nextWait = 1'b0;
                    waitLeft = waitLeft - 1;
                end
                @(posedge CLK_n);
                WAIT_n <= nextWait;
            end
        end
    endtask

    task automatic countCycles();
        logic [31:0] r;
        for (int i = 0; i < 5; i++) begin
            drawRandom(r);
            runInstruction(makeCtrl(1 + int'(r[7:0]) % 5, 3 + int'(r[15:8]) % 4,
                                    1'b0, 1'b0, 1'b0, 1'b0), 0, 0);
        end
    endtask

    task automatic waitAndRefresh();
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            drawRandom(r);
            runInstruction(makeCtrl(2, 4, 1'b0, 1'b0, 1'b0, 1'b0), 1 + int'(r[3:0]) % 4, 0);
        end
    endtask

    task automatic grantBus();
        cpu_pkg::cycleCtrl_t c;
        c = makeCtrl(2, 4, 1'b0, 1'b0, 1'b0, 1'b0);
        @(posedge CLK_n);
        cycleCtrl <= c;
        do begin
            @(negedge CLK_n);
        end while (!(MC == 3'd1 && TS == 3'd2));
        @(posedge CLK_n);
        BUSRQ_n <= 1'b0;
        do begin
            @(negedge CLK_n);
        end while (BUSAK_n);
        // The grant comes at the end of the first machine cycle
        compareMCycle(MC, 3'd1, "MC at grant");
        compareTState(TS, 3'd4, "TS at grant");
        repeat (3) begin
            @(negedge CLK_n);
            compareTState(TS, 3'd4, "TS during grant");
            compareLevel(BUSAK_n, 1'b0, "BUSAK_n during grant");
        end
        @(posedge CLK_n);
        BUSRQ_n <= 1'b1;
        do begin
            @(negedge CLK_n);
            compareTState(TS, 3'd4, "TS before release");
        end while (!BUSAK_n);
        @(negedge CLK_n);
        compareMCycle(MC, 3'd2, "MC after release");
        compareTState(TS, 3'd1, "TS after release");
        finishInstr(c);
    endtask

    task automatic takeInterrupts();
        cpu_pkg::cycleCtrl_t eiCtrl;
        eiCtrl = makeCtrl(1, 4, 1'b0, 1'b1, 1'b0, 1'b0);
        intLine = 1'b0;
        runInstruction(nopCtrl, 0, 0);
        runInstruction(nopCtrl, 0, 0);
        compareLevel(IntCycle_n, 1'b1, "IntCycle_n with interrupts off");
        runInstruction(eiCtrl, 0, 0);
        compareLevel(IntE, 1'b1, "IntE after EI");
        runInstruction(nopCtrl, 0, 0);
        intLine = 1'b1;
        runInstruction(nopCtrl, 0, `CPU_ACK_WAITS);
        compareLevel(IntCycle_n, 1'b0, "IntCycle_n in INT acknowledge");
        compareLevel(IntE, 1'b0, "IntE in INT acknowledge");

        // NMI and INT pending together
        runInstruction(eiCtrl, 0, 0);
        intLine = 1'b0;
        nmiLine = 1'b0;
        runInstruction(nopCtrl, 0, 0);
        intLine = 1'b1;
        runInstruction(nopCtrl, 0, `CPU_ACK_WAITS);
        compareLevel(NmiCycle_n, 1'b0, "NmiCycle_n in NMI acknowledge");
        compareLevel(IntCycle_n, 1'b1, "IntCycle_n in NMI acknowledge");
        compareLevel(IntE, 1'b0, "IntE in NMI acknowledge");
        nmiLine = 1'b1;
        runInstruction(makeCtrl(2, 4, 1'b0, 1'b0, 1'b0, 1'b1), 0, 0);
        compareLevel(IntE, 1'b1, "IntE after RETN");
        runInstruction(makeCtrl(1, 4, 1'b0, 1'b0, 1'b1, 1'b0), 0, 0);
        compareLevel(IntE, 1'b0, "IntE after DI");
    endtask

    task automatic haltAndWake();
        runInstruction(makeCtrl(1, 4, 1'b1, 1'b0, 1'b0, 1'b0), 0, 0);
        runInstruction(nopCtrl, 0, 0);
        compareLevel(HALT_n, 1'b0, "HALT_n after HALT");
        nmiLine = 1'b0;
        runInstruction(nopCtrl, 0, 0);
        compareLevel(HALT_n, 1'b0, "HALT_n before NMI acceptance");
        nmiLine = 1'b1;
        runInstruction(nopCtrl, 0, `CPU_ACK_WAITS);
        compareLevel(HALT_n, 1'b1, "HALT_n after NMI acceptance");
        compareLevel(NmiCycle_n, 1'b0, "NmiCycle_n leaving halt");
        runInstruction(nopCtrl, 0, 0);
        compareLevel(NmiCycle_n, 1'b1, "NmiCycle_n after acknowledge");
    endtask

    task automatic multiplyRandom();
        logic [31:0] a;
        logic [31:0] b;
        cpu_pkg::mulProduct_t expected;
        for (int i = 0; i < 6; i++) begin
            drawRandom(a);
            drawRandom(b);
            @(posedge CLK_n);
            mulLoad  <= 1'b1;
            byteMode <= i[0];
            mulA     <= a[15:0];
            mulB     <= b[15:0];
            @(posedge CLK_n);
            mulLoad <= 1'b0;
            if (i[0]) begin
                repeat (`CPU_MUL_BYTE_STEPS) @(posedge CLK_n);
                @(negedge CLK_n);
                expected = {16'(a[7:0]) * 16'(b[7:0]), 16'h0};
                compareProduct({mulProduct[31:16], 16'h0}, expected, "byte product");
            end else begin
                repeat (`CPU_MUL_WORD_STEPS) @(posedge CLK_n);
                @(negedge CLK_n);
                expected = cpu_pkg::mulProduct_t'(a[15:0]) * cpu_pkg::mulProduct_t'(b[15:0]);
                compareProduct(mulProduct, expected, "word product");
            end
        end
    endtask

    // Watchdog sized from the clock budget of all tests
    initial begin
        #(TEST_COUNT * CLOCKS_PER_TEST * CLK_PERIOD);
        $display("Timeout: the DUT stopped responding before the tests completed");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        nopCtrl    = makeCtrl(1, 4, 1'b0, 1'b0, 1'b0, 1'b0);
        CEN        = 1'b1;
        WAIT_n     = 1'b1;
        INT_n      = 1'b1;
        NMI_n      = 1'b1;
        BUSRQ_n    = 1'b1;
        mulLoad    = 1'b0;
        byteMode   = 1'b0;
        cycleCtrl  = nopCtrl;
        mulA       = '0;
        mulB       = '0;
        intLine    = 1'b1;
        nmiLine    = 1'b1;
        rngState   = 32'd58422;
        errorCount = 0;

        wait (RESET_n === 1'b1);
        finishInstr(nopCtrl);
        compareLevel(IntE, 1'b0, "IntE after reset");

        countCycles();
        waitAndRefresh();
        grantBus();
        takeInterrupts();
        haltAndWake();
        multiplyRandom();

        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/inputSync.sv
logic/intControl.sv
logic/cycleSequencer.sv
logic/mulUnit.sv
logic/cpuTiming.sv
test/clockGen.sv
test/cpuTiming_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuTiming_tb -f src.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
